// ==== src.f ====
design/exe_pkg.sv
design/exe_ctrl.sv
design/forward.sv
design/alu.sv
design/mul_0.sv
design/mul_1.sv
design/exe.sv
testbench/exe_tb.sv

// ==== testbench/exe_tb.sv ====
`timescale 1ns/1ns

module exe_tb;
    import exe_pkg::*;

    typedef struct packed {
        logic [31:0] due;
        result_t     res;
    } expect_t;

    localparam int n_alu_rand  = 100;
    localparam int n_fwd       = 80;
    localparam int n_mul       = 3 * 36;
    localparam int n_mixed     = 400;
    // Two lanes per slot, two setup slots for corner values
    localparam int n_instr     = 2 * (n_alu_rand + n_fwd + 2 + n_mul + n_mixed);
    localparam int cycle_limit = 4 * n_instr + 100;

    logic        clk;
    logic        reset;
    issue_t      lane0;
    issue_t      lane1;
    result_t     wb0;
    result_t     wb1;
    logic        issue_ready;
    word_t       regs [32];
    word_t       committed [32];
    expect_t     port0_q [$];
    expect_t     port1_q [$];
    expect_t     commit_q [$];
    int          cycle = 0;
    int          ready_low_cycle = -1;
    logic [31:0] rng_state = 32'hbf1a_b352;
    string       test_name = "reset";

    exe exe_inst (
        .clk         (clk),
        .reset       (reset),
        .lane0       (lane0),
        .lane1       (lane1),
        .wb0         (wb0),
        .wb1         (wb1),
        .issue_ready (issue_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > cycle_limit) begin
            fail_run("Timeout, the stimulus did not finish within the cycle limit");
        end
    end

    function automatic logic [31:0] pick(input int range);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return (rng_state >> 16) % range;
    endfunction

    // Full 32-bit word from two draws
    function automatic word_t rand_word();
        word_t w;
        w[31:16] = 16'(pick(65536));
        w[15:0]  = 16'(pick(65536));
        return w;
    endfunction

    function automatic reg_addr_t rand_reg(input int lo, input int hi);
        return 5'(lo + pick(hi - lo + 1));
    endfunction

    function automatic issue_t make_op(input itype_e itype, input logic [3:0] op,
                                       input reg_addr_t rd, input reg_addr_t rj,
                                       input reg_addr_t rk);
        issue_t u;
        u = '0;
        u.en = 1'b1;
        u.uop.itype = itype;
        u.uop.op = op;
        u.rd = rd;
        u.rj = rj;
        u.rk = rk;
        return u;
    endfunction

    // Lane1 is younger and never reads what lane0 writes in the same slot
    function automatic issue_t drop_cross_dep(input issue_t l0, input issue_t l1);
        issue_t u;
        u = l1;
        if (l0.en && l0.rd != '0) begin
            if (u.rj == l0.rd) begin
                u.rj = '0;
            end
            if (u.rk == l0.rd) begin
                u.rk = '0;
            end
        end
        return u;
    endfunction

    // Expected value straight from the instruction rules
    function automatic word_t ref_result(input itype_e itype, input logic [3:0] op,
                                         input word_t a, input word_t b);
        logic [63:0] prod;
        logic [63:0] wide;
        word_t       res;
        if (itype == itype_mul) begin
            if (op == mul_hi) begin
                prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            end else begin
                prod = {32'b0, a} * {32'b0, b};
            end
            res = (op == mul_lo) ? prod[31:0] : prod[63:32];
        end else begin
            wide = {{32{a[31]}}, a} >> b[4:0];
            case (op)
                alu_add:  res = a + b;
                alu_sub:  res = a - b;
                alu_slt:  res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
                alu_sltu: res = {31'b0, a < b};
                alu_and:  res = a & b;
                alu_or:   res = a | b;
                alu_xor:  res = a ^ b;
                alu_nor:  res = ~(a | b);
                alu_sll:  res = a << b[4:0];
                alu_srl:  res = a >> b[4:0];
                alu_sra:  res = wide[31:0];
                default:  res = '0;
            endcase
        end
        return res;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_result(input string name, input result_t exp, input result_t act);
        string msg;
        if (exp.en ? (act !== exp) : (act.en !== 1'b0)) begin
            msg = $sformatf("Mismatch %s: expected en=%b rd=%0d data=%h,",
                            name, exp.en, exp.rd, exp.data);
            fail_run($sformatf("%s actual en=%b rd=%0d data=%h", msg, act.en, act.rd, act.data));
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch %s issue_ready: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Register file catches up one cycle after a result leaves its port
    task automatic commit_due();
        int i;
        i = 0;
        while (i < commit_q.size()) begin
            if (commit_q[i].due < cycle) begin
                if (commit_q[i].res.rd != '0) begin
                    committed[commit_q[i].res.rd] = commit_q[i].res.data;
                end
                commit_q.delete(i);
            end else begin
                i++;
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            commit_due();
            lane0 = '0;
            lane1 = '0;
        end
    endtask

    task automatic send(input issue_t l0, input issue_t l1);
        expect_t e0;
        expect_t e1;
        @(negedge clk);
        commit_due();
        while (!issue_ready) begin
            lane0 = '0;
            lane1 = '0;
            @(negedge clk);
            commit_due();
        end
        // Register 0 gets junk data, the DUT must still read zero
        l0.data0 = (l0.rj == '0) ? rand_word() : committed[l0.rj];
        l0.data1 = (l0.rk == '0) ? rand_word() : committed[l0.rk];
        l1.data0 = (l1.rj == '0) ? rand_word() : committed[l1.rj];
        l1.data1 = (l1.rk == '0) ? rand_word() : committed[l1.rk];
        e0.res = {1'b1, l0.rd, ref_result(l0.uop.itype, l0.uop.op, regs[l0.rj], regs[l0.rk])};
        e0.due = (l0.uop.itype == itype_mul) ? cycle + 2 : cycle + 1;
        e1.res = {1'b1, l1.rd, ref_result(l1.uop.itype, l1.uop.op, regs[l1.rj], regs[l1.rk])};
        e1.due = cycle + 1;
        if (l0.en) begin
            port0_q.push_back(e0);
            commit_q.push_back(e0);
            if (l0.uop.itype == itype_mul) begin
                ready_low_cycle = cycle + 1;
            end
            if (l0.rd != '0) begin
                regs[l0.rd] = e0.res.data;
            end
        end
        if (l1.en) begin
            port1_q.push_back(e1);
            commit_q.push_back(e1);
            if (l1.rd != '0) begin
                regs[l1.rd] = e1.res.data;
            end
        end
        lane0 = l0;
        lane1 = l1;
    endtask

    initial begin
        result_t exp0;
        result_t exp1;
        expect_t head;
        wait (reset === 1'b0);
        forever begin
            @(negedge clk);
            exp0 = '0;
            exp1 = '0;
            if (port0_q.size() > 0 && port0_q[0].due == cycle) begin
                head = port0_q.pop_front();
                exp0 = head.res;
            end
            if (port1_q.size() > 0 && port1_q[0].due == cycle) begin
                head = port1_q.pop_front();
                exp1 = head.res;
            end
            check_result({test_name, " wb0"}, exp0, wb0);
            check_result({test_name, " wb1"}, exp1, wb1);
            check_ready(test_name, cycle != ready_low_cycle, issue_ready);
        end
    end

    initial begin
        issue_t    l0;
        issue_t    l1;
        reg_addr_t prev_rd0;
        reg_addr_t prev_rd1;
        reg_addr_t srcs [4];
        reset = 1'b1;
        // Live ops during reset must be discarded
        lane0 = make_op(itype_mul, mul_lo, 5'd1, 5'd1, 5'd2);
        lane1 = make_op(itype_alu, alu_add, 5'd2, 5'd3, 5'd4);
        for (int i = 0; i < 32; i++) begin
            regs[i] = (i == 0) ? '0 : rand_word();
            committed[i] = regs[i];
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        check_result("reset wb0", '0, wb0);
        check_result("reset wb1", '0, wb1);
        check_ready("reset", 1'b1, issue_ready);
        lane0 = '0;
        lane1 = '0;
        reset = 1'b0;
        idle(2);

        // Sources 1..15 stay untouched here
        test_name = "alu_random";
        for (int i = 0; i < n_alu_rand; i++) begin
            send(make_op(itype_alu, 4'(pick(11)), rand_reg(16, 31), rand_reg(1, 15),
                         rand_reg(1, 15)),
                 make_op(itype_alu, 4'(pick(11)), rand_reg(16, 31), rand_reg(1, 15),
                         rand_reg(1, 15)));
        end

        test_name = "alu_forward";
        prev_rd0 = 5'd1;
        prev_rd1 = 5'd2;
        for (int i = 0; i < n_fwd; i++) begin
            for (int s = 0; s < 4; s++) begin
                case (pick(4))
                    0: srcs[s] = prev_rd0;
                    1: srcs[s] = prev_rd1;
                    2: srcs[s] = 5'd0;
                    default: srcs[s] = rand_reg(1, 7);
                endcase
            end
            l0 = make_op(itype_alu, 4'(pick(11)), rand_reg(1, 7), srcs[0], srcs[1]);
            l1 = make_op(itype_alu, 4'(pick(11)), rand_reg(1, 7), srcs[2], srcs[3]);
            // Same rd on both lanes sets up a double match next cycle
            if (pick(4) == 0) begin
                l1.rd = l0.rd;
            end
            l1 = drop_cross_dep(l0, l1);
            send(l0, l1);
            prev_rd0 = l0.rd;
            prev_rd1 = l1.rd;
        end

        // Corner values into r20..r23: 0, -1, 0x80000000, 1
        test_name = "mul";
        send(make_op(itype_alu, alu_add, 5'd20, 5'd0, 5'd0),
             make_op(itype_alu, alu_nor, 5'd21, 5'd0, 5'd0));
        send(make_op(itype_alu, alu_sll, 5'd22, 5'd21, 5'd21),
             make_op(itype_alu, alu_sltu, 5'd23, 5'd0, 5'd21));
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 36; i++) begin
                l0 = make_op(itype_mul, k[3:0], rand_reg(25, 27),
                             5'((i / 6 < 4) ? 20 + i / 6 : 4 + i / 6),
                             5'((i % 6 < 4) ? 20 + i % 6 : 4 + i % 6));
                l1 = make_op(itype_alu, 4'(pick(11)), rand_reg(16, 19), rand_reg(1, 15),
                             rand_reg(1, 15));
                l1.en = (pick(2) == 1);
                send(l0, l1);
            end
        end

        test_name = "mixed";
        for (int i = 0; i < n_mixed; i++) begin
            if (pick(4) == 0) begin
                l0 = make_op(itype_mul, 4'(pick(3)), rand_reg(0, 31), rand_reg(0, 31),
                             rand_reg(0, 31));
            end else begin
                l0 = make_op(itype_alu, 4'(pick(11)), rand_reg(0, 31), rand_reg(0, 31),
                             rand_reg(0, 31));
            end
            l1 = make_op(itype_alu, 4'(pick(11)), rand_reg(0, 31), rand_reg(0, 31),
                         rand_reg(0, 31));
            l0.en = (pick(8) != 0);
            l1.en = (pick(4) != 0);
            if (l0.en && l0.uop.itype == itype_mul && l1.rd == l0.rd) begin
                l1.rd = l0.rd + 5'd1;
            end
            l1 = drop_cross_dep(l0, l1);
            send(l0, l1);
        end

        test_name = "drain";
        idle(6);
        if (port0_q.size() != 0 || port1_q.size() != 0) begin
            fail_run("Some expected write-port results never appeared");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

// ==== design/exe.sv ====
`timescale 1ns/1ns

module exe (
    input  logic             clk,
    input  logic             reset,
    input  exe_pkg::issue_t  lane0,
    input  exe_pkg::issue_t  lane1,
    output exe_pkg::result_t wb0,
    output exe_pkg::result_t wb1,
    output logic             issue_ready
);
    import exe_pkg::*;

    word_t    eu0_sr0;
    word_t    eu0_sr1;
    word_t    eu1_sr0;
    word_t    eu1_sr1;
    word_t    alu0_result;
    word_t    alu1_result;
    alu_op_e  alu0_op;
    alu_op_e  alu1_op;
    logic     mul_start;
    mul_mid_t mul_mid;
    result_t  mul_result;

    exe_ctrl u_exe_ctrl (
        .clk         (clk),
        .reset       (reset),
        .lane0       (lane0),
        .lane1       (lane1),
        .alu0_result (alu0_result),
        .alu1_result (alu1_result),
        .mul_result  (mul_result),
        .mul_start   (mul_start),
        .alu0_op     (alu0_op),
        .alu1_op     (alu1_op),
        .wb0         (wb0),
        .wb1         (wb1),
        .issue_ready (issue_ready)
    );

    forward u_forward (
        .lane0   (lane0),
        .lane1   (lane1),
        .wb0     (wb0),
        .wb1     (wb1),
        .eu0_sr0 (eu0_sr0),
        .eu0_sr1 (eu0_sr1),
        .eu1_sr0 (eu1_sr0),
        .eu1_sr1 (eu1_sr1)
    );

    alu alu0 (
        .op     (alu0_op),
        .sr0    (eu0_sr0),
        .sr1    (eu0_sr1),
        .result (alu0_result)
    );

    alu alu1 (
        .op     (alu1_op),
        .sr0    (eu1_sr0),
        .sr1    (eu1_sr1),
        .result (alu1_result)
    );

    // Multiplier on lane0 only
    mul_0 u_mul_0 (
        .clk   (clk),
        .reset (reset),
        .start (mul_start),
        .op    (mul_op_e'(lane0.uop.op)),
        .rd    (lane0.rd),
        .sr0   (eu0_sr0),
        .sr1   (eu0_sr1),
        .mid   (mul_mid)
    );

    mul_1 u_mul_1 (
        .clk    (clk),
        .reset  (reset),
        .mid    (mul_mid),
        .result (mul_result)
    );

endmodule

// ==== design/mul_1.sv ====
`timescale 1ns/1ns

module mul_1 (
    input  logic              clk,
    input  logic              reset,
    input  exe_pkg::mul_mid_t mid,
    output exe_pkg::result_t  result
);
    import exe_pkg::*;

    logic [63:0] sum;
    logic [63:0] product;
    logic        hi_sel;

    always_comb begin
        sum = {32'b0, mid.pp_ll}
            + ({32'b0, mid.pp_lh} << 16)
            + ({32'b0, mid.pp_hl} << 16)
            + {mid.pp_hh, 32'b0};
    end

    // Sign fix for the signed high product
    assign product = mid.neg ? (~sum + 64'd1) : sum;
    assign hi_sel  = mid.hiu || (mid.op == mul_hi);

    always_ff @(posedge clk) begin
        if (reset) begin
            result.en <= 1'b0;
        end else begin
            result.en <= mid.en;
        end
    end

    always_ff @(posedge clk) begin
        result.rd   <= mid.rd;
        result.data <= hi_sel ? product[63:32] : product[31:0];
    end

    a_out_follows_mid: assert property (
        @(posedge clk) disable iff (reset)
        result.en |-> $past(mid.en)
    );

endmodule

// ==== design/mul_0.sv ====
`timescale 1ns/1ns

module mul_0 (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  exe_pkg::mul_op_e    op,
    input  exe_pkg::reg_addr_t  rd,
    input  exe_pkg::word_t      sr0,
    input  exe_pkg::word_t      sr1,
    output exe_pkg::mul_mid_t   mid
);
    import exe_pkg::*;

    word_t a;
    word_t b;
    logic  is_signed;
    logic  neg;

    assign is_signed = (op == mul_hi);

    // Magnitudes for the signed high product, 0x80000000 stays as 2^31
    always_comb begin
        if (is_signed) begin
            a = sr0[31] ? (~sr0 + 32'd1) : sr0;
            b = sr1[31] ? (~sr1 + 32'd1) : sr1;
        end else begin
            a = sr0;
            b = sr1;
        end
    end

    assign neg = is_signed && (sr0[31] ^ sr1[31]);

    always_ff @(posedge clk) begin
        if (reset) begin
            mid.en <= 1'b0;
        end else begin
            mid.en <= start;
        end
    end

    // Cross products of the 16-bit halves
    always_ff @(posedge clk) begin
        mid.rd    <= rd;
        mid.op    <= op;
        mid.neg   <= neg;
        mid.hiu   <= (op == mul_hiu);
        mid.pp_ll <= a[15:0]  * b[15:0];
        mid.pp_lh <= a[15:0]  * b[31:16];
        mid.pp_hl <= a[31:16] * b[15:0];
        mid.pp_hh <= a[31:16] * b[31:16];
    end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  exe_pkg::alu_op_e op,
    input  exe_pkg::word_t   sr0,
    input  exe_pkg::word_t   sr1,
    output exe_pkg::word_t   result
);
    import exe_pkg::*;

    logic [4:0] shamt;

    // Shift amount from the low bits only
    assign shamt = sr1[4:0];

    always_comb begin
        case (op)
            alu_add: begin
                result = sr0 + sr1;
            end
            alu_sub: begin
                result = sr0 - sr1;
            end
            alu_slt: begin
                result = {31'b0, $signed(sr0) < $signed(sr1)};
            end
            alu_sltu: begin
                result = {31'b0, sr0 < sr1};
            end
            alu_and: begin
                result = sr0 & sr1;
            end
            alu_or: begin
                result = sr0 | sr1;
            end
            alu_xor: begin
                result = sr0 ^ sr1;
            end
            alu_nor: begin
                result = ~(sr0 | sr1);
            end
            alu_sll: begin
                result = sr0 << shamt;
            end
            alu_srl: begin
                result = sr0 >> shamt;
            end
            alu_sra: begin
                result = word_t'($signed(sr0) >>> shamt);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== design/forward.sv ====
`timescale 1ns/1ns

module forward (
    input  exe_pkg::issue_t  lane0,
    input  exe_pkg::issue_t  lane1,
    input  exe_pkg::result_t wb0,
    input  exe_pkg::result_t wb1,
    output exe_pkg::word_t   eu0_sr0,
    output exe_pkg::word_t   eu0_sr1,
    output exe_pkg::word_t   eu1_sr0,
    output exe_pkg::word_t   eu1_sr1
);
    import exe_pkg::*;

    // Newest value for one source, wb1 is the younger port
    function automatic word_t pick(
        input reg_addr_t src,
        input word_t     rf_data,
        input result_t   p0,
        input result_t   p1
    );
        word_t value;
        if (src == '0) begin
            value = '0;
        end else if (p1.en && (p1.rd == src)) begin
            value = p1.data;
        end else if (p0.en && (p0.rd == src)) begin
            value = p0.data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    always_comb begin
        eu0_sr0 = pick(lane0.rj, lane0.data0, wb0, wb1);
        eu0_sr1 = pick(lane0.rk, lane0.data1, wb0, wb1);
    end

    always_comb begin
        eu1_sr0 = pick(lane1.rj, lane1.data0, wb0, wb1);
        eu1_sr1 = pick(lane1.rk, lane1.data1, wb0, wb1);
    end

endmodule

// ==== design/exe_ctrl.sv ====
`timescale 1ns/1ns

module exe_ctrl (
    input  logic             clk,
    input  logic             reset,
    input  exe_pkg::issue_t  lane0,
    input  exe_pkg::issue_t  lane1,
    input  exe_pkg::word_t   alu0_result,
    input  exe_pkg::word_t   alu1_result,
    input  exe_pkg::result_t mul_result,
    output logic             mul_start,
    output exe_pkg::alu_op_e alu0_op,
    output exe_pkg::alu_op_e alu1_op,
    output exe_pkg::result_t wb0,
    output exe_pkg::result_t wb1,
    output logic             issue_ready
);
    import exe_pkg::*;

    result_t alu0_q;
    result_t alu1_q;
    logic    lane0_alu;
    logic    lane1_alu;

    // Class decode
    assign lane0_alu = lane0.en && (lane0.uop.itype == itype_alu);
    assign lane1_alu = lane1.en && (lane1.uop.itype == itype_alu);
    assign mul_start = lane0.en && (lane0.uop.itype == itype_mul);

    assign alu0_op = alu_op_e'(lane0.uop.op);
    assign alu1_op = alu_op_e'(lane1.uop.op);

    always_ff @(posedge clk) begin
        if (reset) begin
            alu0_q.en   <= 1'b0;
            alu1_q.en   <= 1'b0;
            issue_ready <= 1'b1;
        end else begin
            alu0_q.en   <= lane0_alu;
            alu1_q.en   <= lane1_alu;
            // One bubble after each multiply
            issue_ready <= !mul_start;
        end
    end

    always_ff @(posedge clk) begin
        alu0_q.rd   <= lane0.rd;
        alu0_q.data <= alu0_result;
        alu1_q.rd   <= lane1.rd;
        alu1_q.data <= alu1_result;
    end

    // Port 0 shared with the multiplier
    assign wb0 = mul_result.en ? mul_result : alu0_q;
    assign wb1 = alu1_q;

    a_no_issue_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        !issue_ready |-> !(lane0.en || lane1.en)
    );

    a_lane1_alu_only: assert property (
        @(posedge clk) disable iff (reset)
        lane1.en |-> (lane1.uop.itype == itype_alu)
    );

    a_port0_no_collision: assert property (
        @(posedge clk) disable iff (reset)
        !(mul_result.en && alu0_q.en)
    );

endmodule

// ==== design/exe_pkg.sv ====
package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Unit class of a micro-op
    typedef enum logic [0:0] {
        itype_alu = 1'b0,
        itype_mul = 1'b1
    } itype_e;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_slt  = 4'd2,
        alu_sltu = 4'd3,
        alu_and  = 4'd4,
        alu_or   = 4'd5,
        alu_xor  = 4'd6,
        alu_nor  = 4'd7,
        alu_sll  = 4'd8,
        alu_srl  = 4'd9,
        alu_sra  = 4'd10
    } alu_op_e;

    typedef enum logic [3:0] {
        mul_lo  = 4'd0,
        mul_hi  = 4'd1,
        mul_hiu = 4'd2
    } mul_op_e;

    // Op field is read as alu_op_e or mul_op_e by class
    typedef struct packed {
        itype_e     itype;
        logic [3:0] op;
    } uop_t;

    typedef struct packed {
        logic      en;
        uop_t      uop;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        word_t     data0;
        word_t     data1;
    } issue_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } result_t;

    // Between the two multiplier stages
    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        mul_op_e   op;
        logic      neg;
        logic      hiu;
        word_t     pp_ll;
        word_t     pp_lh;
        word_t     pp_hl;
        word_t     pp_hh;
    } mul_mid_t;

endpackage
